/* etx_pkg.sv */
package etx_pkg;

  // ####################################################################
  // packet geometry
  // ####################################################################
  localparam int pw = 104;            // mesh packet width
  localparam int aw = 32;             // address width
  localparam int dw = 32;             // data width

  // field positions inside the 104-bit packet (lsb of each field)
  localparam int access_pos   = 0;
  localparam int write_pos    = 1;
  localparam int datamode_pos = 2;    // 2 bits
  localparam int ctrlmode_pos = 4;    // 4 bits
  localparam int dstaddr_pos  = 8;    // aw bits
  localparam int data_pos     = 40;   // dw bits
  localparam int srcaddr_pos  = 72;   // aw bits

  // ####################################################################
  // link framing
  // ####################################################################
  localparam logic [7:0] frame_first  = 8'h3F;  // beat 0 frame byte
  localparam logic [7:0] frame_second = 8'hFF;  // beat 1 frame byte

  // ####################################################################
  // test mode
  // ####################################################################
  localparam logic [11:0] tx_id   = 12'h000;  // our own link id
  localparam logic [3:0]  rr_code = 4'hD;     // read-response routing

  localparam logic [31:0] test_wr_pattern = 32'h5555_5555;
  localparam logic [31:0] test_rd_pattern = 32'hAAAA_AAAA;

  // 128-bit transmit word, msb first
  typedef struct packed {
    logic [31:0] data;       // top 32 bits
    logic [31:0] srcaddr;
    logic [7:0]  unused_hi;  // always zero
    logic [7:0]  unused_lo;  // always zero
    logic        b0_rd;      // B0: inverted write flag
    logic [6:0]  b0_rsvd;    // B0: burst bits, zero for now
    logic [3:0]  b1_ctrl;    // B1 upper nibble
    logic [3:0]  b1_dst;     // B1 lower nibble, dstaddr[31:28]
    logic [23:0] b4_b2_dst;  // dstaddr[27:4]
    logic [3:0]  b5_dst;     // dstaddr[3:0]
    logic [1:0]  b5_mode;    // datamode
    logic        b5_write;
    logic        b5_access;
  } etx_txword_fields_t;

  // same word seen as the two 64-bit io beats, beat 0 is the low half
  typedef union packed {
    etx_txword_fields_t     f;
    logic [1:0][63:0]       beat;
  } etx_txword_u;

endpackage

/* packet2emesh.sv */
`timescale 1ns/1ps

// splits a flat mesh packet into its fields
module packet2emesh
(
  input  logic [etx_pkg::pw-1:0] packet_in,
  output logic                   write_out,
  output logic [1:0]             datamode_out,
  output logic [3:0]             ctrlmode_out,
  output logic [etx_pkg::aw-1:0] dstaddr_out,
  output logic [etx_pkg::dw-1:0] data_out,
  output logic [etx_pkg::aw-1:0] srcaddr_out
);

  // ####################################################################
  // field decode
  // ####################################################################

  // access bit is not decoded here, the strobe travels beside the packet

  assign write_out    = packet_in[etx_pkg::write_pos];

  // size of the transfer
  assign datamode_out = packet_in[etx_pkg::datamode_pos +: 2];

  // routing / special handling
  assign ctrlmode_out = packet_in[etx_pkg::ctrlmode_pos +: 4];

  // target of the transaction
  assign dstaddr_out  = packet_in[etx_pkg::dstaddr_pos +: etx_pkg::aw];

  // write data, or dummy for reads
  assign data_out     = packet_in[etx_pkg::data_pos +: etx_pkg::dw];

  // on reads this is the return address
  assign srcaddr_out  = packet_in[etx_pkg::srcaddr_pos +: etx_pkg::aw];

endmodule

/* synchronizer.sv */
`timescale 1ns/1ps

// two-flop synchronizer for slow asynchronous levels
module synchronizer #(
  parameter int dw_sync = 1
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic [dw_sync-1:0] in,
  output logic [dw_sync-1:0] out
);

  logic [dw_sync-1:0] sync_meta;  // first stage, may go metastable

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sync_meta <= '0;
      out       <= '0;
    end
    else
    begin
      sync_meta <= in;         // capture raw level
      out       <= sync_meta;  // settled copy
    end
  end

endmodule

/* etx_testgen.sv */
`timescale 1ns/1ps

// test-mode traffic source, ping-pongs a write and a read
// to our own chip address
module etx_testgen
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   testmode,
  input  logic [11:0]            chipid,
  output logic [etx_pkg::pw-1:0] test_packet
);

  logic [etx_pkg::pw-1:0] wr_pkt;  // 32-bit write
  logic [etx_pkg::pw-1:0] rd_pkt;  // 32-bit read of same location
  logic [etx_pkg::aw-1:0] test_addr;

  assign test_addr = {chipid, 20'b0};  // chip id sits in the top 12 bits

  always_comb
  begin
    wr_pkt = '0;
    wr_pkt[etx_pkg::access_pos]                    = 1'b1;
    wr_pkt[etx_pkg::write_pos]                     = 1'b1;
    wr_pkt[etx_pkg::datamode_pos +: 2]             = 2'b10;  // 32 bit
    wr_pkt[etx_pkg::dstaddr_pos +: etx_pkg::aw]    = test_addr;
    wr_pkt[etx_pkg::data_pos +: etx_pkg::dw]       = etx_pkg::test_wr_pattern;
    wr_pkt[etx_pkg::srcaddr_pos +: etx_pkg::aw]    = etx_pkg::test_wr_pattern;
  end

  always_comb
  begin
    rd_pkt = '0;
    rd_pkt[etx_pkg::access_pos]                    = 1'b1;
    rd_pkt[etx_pkg::datamode_pos +: 2]             = 2'b10;
    rd_pkt[etx_pkg::dstaddr_pos +: etx_pkg::aw]    = test_addr;
    rd_pkt[etx_pkg::data_pos +: etx_pkg::dw]       = etx_pkg::test_rd_pattern;
    // return address: id, reg group F03, word offset of the rr register
    rd_pkt[etx_pkg::srcaddr_pos +: etx_pkg::aw]    = {etx_pkg::tx_id, 12'hF03, 2'b00,
                                                      etx_pkg::rr_code, 2'b00};
  end

  // write after anything with write clear, reset packet included
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      test_packet <= '0;
    else if (testmode)
    begin
      if (!test_packet[etx_pkg::write_pos])
        test_packet <= wr_pkt;
      else
        test_packet <= rd_pkt;
    end
  end

endmodule

/* etx_framer.sv */
`timescale 1ns/1ps

// packs one mesh transaction into a 128-bit word and
// sends it as two 64-bit beats with a frame byte each
module etx_framer
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enable,        // transmit enable
  input  logic                   access,        // packet strobe
  input  logic                   write,
  input  logic [1:0]             datamode,
  input  logic [3:0]             ctrlmode,
  input  logic [etx_pkg::aw-1:0] dstaddr,
  input  logic [etx_pkg::dw-1:0] data,
  input  logic [etx_pkg::aw-1:0] srcaddr,
  output logic [7:0]             tx_frame_par,
  output logic [63:0]            tx_data_par,
  output logic                   sample         // high = ready for a packet
);

  // ####################################################################
  // local state
  // ####################################################################
  etx_pkg::etx_txword_u tx_word;    // word on the wire
  etx_pkg::etx_txword_u new_word;   // word built from the inputs

  logic accept;       // first beat starts
  logic second_beat;  // first beat is out, send the other half

  assign accept      = enable & access & sample;
  assign second_beat = enable & ~sample;

  // ####################################################################
  // word assembly
  // ####################################################################
  always_comb
  begin
    new_word = '0;

    // B5: low dst nibble plus the mode bits
    new_word.f.b5_access = 1'b1;          // always set on the link
    new_word.f.b5_write  = write;
    new_word.f.b5_mode   = datamode;
    new_word.f.b5_dst    = dstaddr[3:0];

    // B4..B2
    new_word.f.b4_b2_dst = dstaddr[27:4];

    // B1
    new_word.f.b1_dst    = dstaddr[31:28];
    new_word.f.b1_ctrl   = ctrlmode;

    // B0, read flag on top, burst bits stay zero
    new_word.f.b0_rd     = ~write;
    new_word.f.b0_rsvd   = 7'd0;

    // two spare bytes left zero
    new_word.f.unused_lo = 8'd0;
    new_word.f.unused_hi = 8'd0;

    // second beat payload
    new_word.f.srcaddr   = srcaddr;
    new_word.f.data      = data;
  end

  // ####################################################################
  // beat sequencing
  // ####################################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sample       <= 1'b1;
      tx_frame_par <= 8'd0;
      tx_word      <= '0;
    end
    else if (accept)            // beat 0 goes out next cycle
    begin
      sample       <= 1'b0;
      tx_frame_par <= etx_pkg::frame_first;
      tx_word      <= new_word;
    end
    else if (second_beat)       // beat 1, word is kept
    begin
      sample       <= 1'b1;
      tx_frame_par <= etx_pkg::frame_second;
    end
    else
    begin
      // idle or enable dropped, clear the wire
      sample       <= 1'b1;
      tx_frame_par <= 8'd0;
      tx_word      <= '0;
    end
  end

  // sample low marks the first beat
  assign tx_data_par = sample ? tx_word.beat[1] : tx_word.beat[0];

endmodule

/* etx_protocol.sv */
`timescale 1ns/1ps

// transmit protocol stage, mesh packet in, framed 64-bit beats out
module etx_protocol
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   testmode,      // self-generated traffic
  // system side
  input  logic                   etx_access,
  input  logic [etx_pkg::pw-1:0] etx_packet,
  input  logic                   tx_enable,
  input  logic [11:0]            chipid,
  // async waits from the io side
  input  logic                   tx_rd_wait,
  input  logic                   tx_wr_wait,
  // back-pressure
  output logic                   etx_rd_wait,
  output logic                   etx_wr_wait,
  output logic                   etx_wait,      // for the pipeline
  output logic                   etx_io_wait,   // for the arbiter
  // io side
  output logic [7:0]             tx_frame_par,
  output logic [63:0]            tx_data_par
);

  // ####################################################################
  // local signals
  // ####################################################################
  logic [etx_pkg::pw-1:0] test_packet;
  logic [etx_pkg::pw-1:0] etx_packet_mux;
  logic                   access_mux;
  logic                   enable_mux;

  logic                   etx_write;
  logic [1:0]             etx_datamode;
  logic [3:0]             etx_ctrlmode;
  logic [etx_pkg::aw-1:0] etx_dstaddr;
  logic [etx_pkg::dw-1:0] etx_data;
  logic [etx_pkg::aw-1:0] etx_srcaddr;

  logic                   sample;        // framer idle / ready
  logic [1:0]             wait_sync;     // {rd, wr} in clk domain

  // ####################################################################
  // test mode
  // ####################################################################
  etx_testgen u_testgen
  (
    .clk         (clk),
    .reset       (reset),
    .testmode    (testmode),
    .chipid      (chipid),
    .test_packet (test_packet)
  );

  assign etx_packet_mux = testmode ? test_packet : etx_packet;

  // test mode owns the link, no other traffic expected
  assign access_mux = testmode | etx_access;
  assign enable_mux = testmode | tx_enable;

  // ####################################################################
  // decode and frame
  // ####################################################################
  packet2emesh u_p2m
  (
    .packet_in    (etx_packet_mux),
    .write_out    (etx_write),
    .datamode_out (etx_datamode),
    .ctrlmode_out (etx_ctrlmode),
    .dstaddr_out  (etx_dstaddr),
    .data_out     (etx_data),
    .srcaddr_out  (etx_srcaddr)
  );

  etx_framer u_framer
  (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable_mux),
    .access       (access_mux),   // forced strobe, so test mode sends
    .write        (etx_write),
    .datamode     (etx_datamode),
    .ctrlmode     (etx_ctrlmode),
    .dstaddr      (etx_dstaddr),
    .data         (etx_data),
    .srcaddr      (etx_srcaddr),
    .tx_frame_par (tx_frame_par),
    .tx_data_par  (tx_data_par),
    .sample       (sample)
  );

  // ####################################################################
  // wait handling
  // ####################################################################
  synchronizer #(.dw_sync(2)) u_wait_sync
  (
    .clk   (clk),
    .reset (reset),
    .in    ({tx_rd_wait, tx_wr_wait}),
    .out   (wait_sync)
  );

  assign etx_rd_wait = wait_sync[1];
  assign etx_wr_wait = wait_sync[0];

  assign etx_io_wait = ~sample;  // busy with beat 0

  // hold the source while io is busy or the far side pushes back
  assign etx_wait = etx_io_wait | etx_rd_wait | etx_wr_wait;

endmodule

/* tb_etx_protocol.sv */
`timescale 1ns/1ps

// testbench for the transmit protocol stage
module tb_etx_protocol;

  localparam int test_cycles     = 100;              // whole sequence fits in this
  localparam int watchdog_cycles = 4 * test_cycles;

  // dut ports
  logic                   clk;
  logic                   reset;
  logic                   testmode;
  logic                   etx_access;
  logic [etx_pkg::pw-1:0] etx_packet;
  logic                   tx_enable;
  logic [11:0]            chipid;
  logic                   tx_rd_wait;
  logic                   tx_wr_wait;
  logic                   etx_rd_wait;
  logic                   etx_wr_wait;
  logic                   etx_wait;
  logic                   etx_io_wait;
  logic [7:0]             tx_frame_par;
  logic [63:0]            tx_data_par;

  string  test_name;
  integer seed = 32'h10ca;
  int     checks;
  int     value_errors;
  int     protocol_errors;
  int     accepted;          // packets the model took

  // model state updated on rising edges
  logic                   m_busy;    // first beat on the wire
  logic [7:0]             m_frame;
  logic [63:0]            m_data;
  etx_pkg::etx_txword_u   m_word;
  logic [etx_pkg::pw-1:0] m_tg_pkt;  // test generator copy
  logic [etx_pkg::pw-1:0] m_pkt;
  logic                   m_enable;
  logic                   m_access;
  logic                   m_rd1;
  logic                   m_rd2;
  logic                   m_wr1;
  logic                   m_wr2;

  etx_protocol dut
  (
    .clk          (clk),
    .reset        (reset),
    .testmode     (testmode),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .tx_enable    (tx_enable),
    .chipid       (chipid),
    .tx_rd_wait   (tx_rd_wait),
    .tx_wr_wait   (tx_wr_wait),
    .etx_rd_wait  (etx_rd_wait),
    .etx_wr_wait  (etx_wr_wait),
    .etx_wait     (etx_wait),
    .etx_io_wait  (etx_io_wait),
    .tx_frame_par (tx_frame_par),
    .tx_data_par  (tx_data_par)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ####################################################################
  // packet and word builders
  // ####################################################################
  function automatic logic [etx_pkg::pw-1:0] make_packet(input logic wr,
    input logic [1:0] mode, input logic [3:0] ctrl, input logic [31:0] dst,
    input logic [31:0] dat, input logic [31:0] src);
    logic [etx_pkg::pw-1:0] pkt;
    pkt = '0;
    pkt[etx_pkg::access_pos]           = 1'b1;
    pkt[etx_pkg::write_pos]            = wr;
    pkt[etx_pkg::datamode_pos +: 2]    = mode;
    pkt[etx_pkg::ctrlmode_pos +: 4]    = ctrl;
    pkt[etx_pkg::dstaddr_pos +: 32]    = dst;
    pkt[etx_pkg::data_pos +: 32]       = dat;
    pkt[etx_pkg::srcaddr_pos +: 32]    = src;
    return pkt;
  endfunction

  function automatic logic [etx_pkg::pw-1:0] random_packet(input logic wr);
    logic [31:0] dst;
    logic [31:0] dat;
    logic [31:0] src;
    logic [5:0]  bits;   // mode and ctrl
    dst  = $random(seed);
    dat  = $random(seed);
    src  = $random(seed);
    bits = $random(seed);
    return make_packet(wr, bits[1:0], bits[5:2], dst, dat, src);
  endfunction

  function automatic logic [etx_pkg::pw-1:0] test_write_packet(input logic [11:0] chip);
    return make_packet(1'b1, 2'b10, 4'h0, {chip, 20'h0}, etx_pkg::test_wr_pattern,
                       etx_pkg::test_wr_pattern);
  endfunction

  // read returns to id / F03 group / rr register
  function automatic logic [etx_pkg::pw-1:0] test_read_packet(input logic [11:0] chip);
    return make_packet(1'b0, 2'b10, 4'h0, {chip, 20'h0}, etx_pkg::test_rd_pattern,
                       {etx_pkg::tx_id, 12'hF03, 2'b00, etx_pkg::rr_code, 2'b00});
  endfunction

  // two beats from the byte layout with access forced to one
  function automatic etx_pkg::etx_txword_u expected_word(input logic [etx_pkg::pw-1:0] pkt);
    etx_pkg::etx_txword_u w;
    logic [31:0]          dst;
    logic                 wr;
    dst = pkt[etx_pkg::dstaddr_pos +: 32];
    wr  = pkt[etx_pkg::write_pos];
    w.beat[1] = {pkt[etx_pkg::data_pos +: 32], pkt[etx_pkg::srcaddr_pos +: 32]};
    w.beat[0] = {16'h0000, ~wr, 7'b0, pkt[etx_pkg::ctrlmode_pos +: 4], dst[31:28],
                 dst[27:4], dst[3:0], pkt[etx_pkg::datamode_pos +: 2], wr, 1'b1};
    return w;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      value_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // ####################################################################
  // reference model and per-cycle checks
  // ####################################################################
  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      m_busy   = 1'b0;
      m_frame  = 8'd0;
      m_data   = 64'd0;
      m_word   = '0;
      m_tg_pkt = '0;
      {m_rd1, m_rd2, m_wr1, m_wr2} = 4'b0;
    end
    else
    begin
      m_enable = testmode | tx_enable;     // test mode forces both
      m_access = testmode | etx_access;
      m_pkt    = testmode ? m_tg_pkt : etx_packet;
      if (m_enable && m_access && !m_busy)
      begin
        m_word  = expected_word(m_pkt);
        m_busy  = 1'b1;
        m_frame = etx_pkg::frame_first;
        m_data  = m_word.beat[0];
        accepted++;
      end
      else if (m_enable && m_busy)
      begin
        m_busy  = 1'b0;
        m_frame = etx_pkg::frame_second;
        m_data  = m_word.beat[1];
      end
      else
      begin
        m_busy  = 1'b0;                  // idle or enable dropped
        m_frame = 8'd0;
        m_data  = 64'd0;
        m_word  = '0;
      end
      if (testmode)                      // toggles every edge
        m_tg_pkt = m_tg_pkt[etx_pkg::write_pos] ? test_read_packet(chipid)
                                                 : test_write_packet(chipid);
      m_rd2 = m_rd1;
      m_rd1 = tx_rd_wait;
      m_wr2 = m_wr1;
      m_wr1 = tx_wr_wait;
    end
  end

  // registered outputs settle before the falling edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      check_val("tx_frame_par", m_frame, tx_frame_par);
      check_val("tx_data_par", m_data, tx_data_par);
      check_val("etx_io_wait", m_busy, etx_io_wait);
      check_val("etx_rd_wait", m_rd2, etx_rd_wait);
      check_val("etx_wr_wait", m_wr2, etx_wr_wait);
      check_val("etx_wait", m_busy | m_rd2 | m_wr2, etx_wait);
    end
  end

  frame_pair: assert property (@(posedge clk) disable iff (reset)
    (tx_frame_par == etx_pkg::frame_first && (testmode || tx_enable))
      |=> tx_frame_par == etx_pkg::frame_second)
  else
  begin
    protocol_errors++;
    $display("first beat was not followed by the second beat at %0t", $time);
  end

  first_busy: assert property (@(posedge clk) disable iff (reset)
    (tx_frame_par == etx_pkg::frame_first) |-> etx_io_wait)
  else
  begin
    protocol_errors++;
    $display("io wait was low during a first beat at %0t", $time);
  end

  // ####################################################################
  // stimulus
  // ####################################################################
  initial
  begin
    logic [etx_pkg::pw-1:0] pkt;
    etx_pkg::etx_txword_u   w;
    int                     base;
    logic                   wr_bit;
    clk        = 1'b0;
    reset      = 1'b1;
    testmode   = 1'b0;
    etx_access = 1'b0;
    etx_packet = '0;
    tx_enable  = 1'b0;
    chipid     = 12'h0;
    tx_rd_wait = 1'b0;
    tx_wr_wait = 1'b0;
    test_name  = "reset";
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_val("frame after reset", 64'd0, tx_frame_par);
    check_val("data after reset", 64'd0, tx_data_par);
    check_val("waits after reset", 64'd0, {etx_rd_wait, etx_wr_wait, etx_wait, etx_io_wait});

    // one write in two beats
    @(negedge clk);
    test_name  = "single";
    base       = accepted;
    tx_enable  = 1'b1;
    pkt        = random_packet(1'b1);
    etx_packet = pkt;
    etx_access = 1'b1;
    w          = expected_word(pkt);
    @(negedge clk);
    etx_access = 1'b0;
    check_val("beat 0 frame", etx_pkg::frame_first, tx_frame_par);
    check_val("beat 0 data", w.beat[0], tx_data_par);
    check_val("B0 read flag", 1'b0, tx_data_par[47]);   // inverted write
    @(negedge clk);
    check_val("beat 1 frame", etx_pkg::frame_second, tx_frame_par);
    check_val("beat 1 data over srcaddr",
              {pkt[etx_pkg::data_pos +: 32], pkt[etx_pkg::srcaddr_pos +: 32]}, tx_data_par);
    @(negedge clk);
    check_val("accepted", base + 1, accepted);

    // access held for one accept every two edges
    test_name = "back_to_back";
    base      = accepted;
    for (int i = 0; i < 20; i++)
    begin
      wr_bit     = $random(seed);
      etx_packet = random_packet(wr_bit);
      etx_access = 1'b1;
      @(negedge clk);
    end
    etx_access = 1'b0;
    repeat (2) @(negedge clk);
    check_val("accepted", base + 10, accepted);

    // nothing leaves with tx_enable low
    test_name  = "tx_disabled";
    base       = accepted;
    tx_enable  = 1'b0;
    etx_access = 1'b1;
    repeat (6)
    begin
      etx_packet = random_packet(1'b1);
      @(negedge clk);
      check_val("frame", 64'd0, tx_frame_par);
    end
    etx_access = 1'b0;
    check_val("accepted", base, accepted);

    // test mode overrides system traffic
    test_name  = "testmode";
    base       = accepted;
    chipid     = $random(seed);
    etx_packet = random_packet(1'b0);
    etx_access = 1'b1;
    testmode   = 1'b1;
    repeat (9) @(negedge clk);
    testmode   = 1'b0;           // enable drops mid-packet and the held packet is a write
    @(negedge clk);
    testmode   = 1'b1;           // write phase now lines up with the accept
    w          = expected_word(test_write_packet(chipid));
    @(negedge clk);
    check_val("test write beat 0", w.beat[0], tx_data_par);
    repeat (3) @(negedge clk);
    testmode   = 1'b0;
    etx_access = 1'b0;
    repeat (2) @(negedge clk);
    check_val("accepted", base + 7, accepted);

    // wait levels take two edges through the synchronizer
    test_name  = "wait_sync";
    tx_rd_wait = 1'b1;
    @(negedge clk);
    check_val("rd wait after one edge", 1'b0, etx_rd_wait);
    @(negedge clk);
    check_val("rd wait after two edges", 1'b1, etx_rd_wait);
    check_val("etx_wait on rd", 1'b1, etx_wait);
    tx_wr_wait = 1'b1;
    repeat (2) @(negedge clk);
    check_val("wr wait after two edges", 1'b1, etx_wr_wait);
    tx_rd_wait = 1'b0;
    tx_wr_wait = 1'b0;
    @(negedge clk);
    check_val("etx_wait one edge after release", 1'b1, etx_wait);
    @(negedge clk);
    check_val("waits cleared", 64'd0, {etx_rd_wait, etx_wr_wait, etx_wait});

    @(negedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("test sequence did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* project.f */
etx_pkg.sv
packet2emesh.sv
synchronizer.sv
etx_testgen.sv
etx_framer.sv
etx_protocol.sv
tb_etx_protocol.sv

/* Bender.yml */
package:
  name: etx_protocol

sources:
  # rtl, package first
  - etx_pkg.sv
  - packet2emesh.sv
  - synchronizer.sv
  - etx_testgen.sv
  - etx_framer.sv
  - etx_protocol.sv

  # testbench
  - target: simulation
    files:
      - tb_etx_protocol.sv
